/* design/dino_pkg.sv */
package dino_pkg;

    // Horizontal timing in pixel clocks
    localparam int h_active = 1280;
    localparam int h_front  = 32;
    localparam int h_sync   = 192;
    localparam int h_back   = 96;

    // Vertical timing in lines
    localparam int v_active = 480;
    localparam int v_front  = 10;
    localparam int v_sync   = 2;
    localparam int v_back   = 33;

    // Background band limits
    localparam int ground_line_row = 280;
    localparam int dark_ground_row = 300;

    // Cycles of daylight after reset
    localparam int night_cycles_default = 100_000_000;

    typedef logic [10:0] coord_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    localparam rgb_t sky_day      = {8'd135, 8'd206, 8'd235};
    localparam rgb_t sky_night    = {8'd10,  8'd10,  8'd40};
    localparam rgb_t ground_light = {8'd139, 8'd69,  8'd19};
    localparam rgb_t ground_dark  = {8'd100, 8'd40,  8'd10};
    localparam rgb_t line_color   = {8'd0,   8'd0,   8'd0};
    localparam rgb_t dino_color   = {8'd83,  8'd83,  8'd83};
    localparam rgb_t digit_color  = {8'd0,   8'd0,   8'd0};

    localparam int sprite_size = 16;

    // One row per entry, MSB is the leftmost pixel, 1 is opaque
    localparam logic [0:15][15:0] dino_mask = {
        16'h01FE, 16'h037F, 16'h03FF, 16'h03FF,
        16'h03E0, 16'h03FC, 16'h87C0, 16'h8FF0,
        16'hDFD0, 16'hFFC0, 16'h7FC0, 16'h3F80,
        16'h1F00, 16'h1980, 16'h1080, 16'h18C0
    };

    // 8x8 digit glyphs, top row in the high byte
    localparam logic [0:9][0:7][7:0] font_rom = {
        64'h3C666E7E76663C00,
        64'h1818381818187E00,
        64'h3C66061C30667E00,
        64'h3C66061C06663C00,
        64'h0C1C2C4C7E0C0C00,
        64'h7E607C0606663C00,
        64'h3C66607C66663C00,
        64'h7E060C1830303000,
        64'h3C66663C66663C00,
        64'h3C66663E06663C00
    };

    // Write data seen as a coordinate or as a score digit
    typedef union packed {
        struct packed {
            logic [20:0] unused;
            coord_t      pos;
        } coord_view;
        struct packed {
            logic [27:0] unused;
            logic [3:0]  digit;
        } score_view;
    } bus_word_u;

    typedef enum logic [2:0] {
        addr_dino_x  = 3'd0,
        addr_dino_y  = 3'd1,
        addr_score   = 3'd2,
        addr_score_x = 3'd3,
        addr_score_y = 3'd4
    } reg_addr_t;

endpackage

/* design/vga_timing.sv */
`timescale 1ns/1ps

module vga_timing #(
    parameter int H_ACTIVE = dino_pkg::h_active,
    parameter int H_FRONT  = dino_pkg::h_front,
    parameter int H_SYNC   = dino_pkg::h_sync,
    parameter int H_BACK   = dino_pkg::h_back,
    parameter int V_ACTIVE = dino_pkg::v_active,
    parameter int V_FRONT  = dino_pkg::v_front,
    parameter int V_SYNC   = dino_pkg::v_sync,
    parameter int V_BACK   = dino_pkg::v_back
) (
    input  logic            clk,
    input  logic            reset,
    output dino_pkg::coord_t hcount,
    output dino_pkg::coord_t vcount,
    output logic            active,
    output logic            hsync_n,
    output logic            vsync_n
);

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    logic end_of_line;
    logic end_of_frame;

    assign end_of_line  = (hcount == H_TOTAL - 1);
    assign end_of_frame = (vcount == V_TOTAL - 1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hcount <= '0;
            vcount <= '0;
        end else begin
            if (end_of_line) begin
                hcount <= '0;
                // Line counter moves once per line
                vcount <= end_of_frame ? '0 : vcount + 1'b1;
            end else begin
                hcount <= hcount + 1'b1;
            end
        end
    end

    // Sync pulses sit between front and back porch, low while asserted
    assign hsync_n = !((hcount >= H_ACTIVE + H_FRONT) &&
                       (hcount <  H_ACTIVE + H_FRONT + H_SYNC));
    assign vsync_n = !((vcount >= V_ACTIVE + V_FRONT) &&
                       (vcount <  V_ACTIVE + V_FRONT + V_SYNC));
    assign active  = (hcount < H_ACTIVE) && (vcount < V_ACTIVE);

endmodule

/* design/reg_decode.sv */
`timescale 1ns/1ps

module reg_decode (
    input  logic                clk,
    input  logic                reset,
    input  logic                chipselect,
    input  logic                write,
    input  dino_pkg::reg_addr_t address,
    input  dino_pkg::bus_word_u writedata,
    output dino_pkg::coord_t    dino_x,
    output dino_pkg::coord_t    dino_y,
    output logic [3:0]          score_digit,
    output dino_pkg::coord_t    score_x,
    output dino_pkg::coord_t    score_y
);

    import dino_pkg::*;

    logic wr_en;

    assign wr_en = chipselect && write;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dino_x      <= 11'd100;
            dino_y      <= 11'd100;
            score_digit <= 4'd0;
            score_x     <= 11'd25;
            score_y     <= 11'd41;
        end else if (wr_en) begin
            // The address also selects how the word is read
            case (address)
                addr_dino_x: begin
                    dino_x <= writedata.coord_view.pos;
                end
                addr_dino_y: begin
                    dino_y <= writedata.coord_view.pos;
                end
                addr_score: begin
                    score_digit <= writedata.score_view.digit;
                end
                addr_score_x: begin
                    score_x <= writedata.coord_view.pos;
                end
                addr_score_y: begin
                    score_y <= writedata.coord_view.pos;
                end
                // Addresses 5 to 7 have no register behind them
                default: begin
                end
            endcase
        end
    end

endmodule

/* design/pixel_compose.sv */
`timescale 1ns/1ps

module pixel_compose #(
    parameter int NIGHT_CYCLES = dino_pkg::night_cycles_default
) (
    input  logic             clk,
    input  logic             reset,
    input  dino_pkg::coord_t hcount,
    input  dino_pkg::coord_t vcount,
    input  dino_pkg::coord_t dino_x,
    input  dino_pkg::coord_t dino_y,
    input  logic [3:0]       score_digit,
    input  dino_pkg::coord_t score_x,
    input  dino_pkg::coord_t score_y,
    output dino_pkg::rgb_t   pixel_color
);

    import dino_pkg::*;

    // Wide enough to hold NIGHT_CYCLES itself
    localparam int TIMER_W = $clog2(NIGHT_CYCLES + 2);

    logic [TIMER_W-1:0] night_timer;
    logic               night;

    coord_t dx;
    coord_t dy;
    coord_t sx;
    coord_t sy;
    logic   in_dino;
    logic   in_digit;
    rgb_t   next_color;

    // Day/night timer stops once it reaches the limit
    assign night = (night_timer == TIMER_W'(NIGHT_CYCLES));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            night_timer <= '0;
        end else if (!night) begin
            night_timer <= night_timer + 1'b1;
        end
    end

    // Offsets into the sprite and digit boxes
    assign dx = hcount - dino_x;
    assign dy = vcount - dino_y;
    assign sx = hcount - score_x;
    assign sy = vcount - score_y;

    // The lower bound check keeps the offsets from wrapping
    assign in_dino  = (hcount >= dino_x) && (dx < sprite_size) &&
                      (vcount >= dino_y) && (dy < sprite_size);
    assign in_digit = (hcount >= score_x) && (sx < 8) &&
                      (vcount >= score_y) && (sy < 8);

    always_comb begin
        // Background bands
        if (vcount < ground_line_row) begin
            next_color = night ? sky_night : sky_day;
        end else if (vcount == ground_line_row) begin
            next_color = line_color;
        end else if (vcount <= dark_ground_row) begin
            next_color = ground_light;
        end else begin
            next_color = ground_dark;
        end

        // Inverted column offset picks the bit, MSB on the left
        if (in_dino && dino_mask[dy[3:0]][~dx[3:0]]) begin
            next_color = dino_color;
        end

        // Score digit goes last, codes above 9 are blank
        if (in_digit && (score_digit < 4'd10)) begin
            if (font_rom[score_digit][sy[2:0]][~sx[2:0]]) begin
                next_color = digit_color;
            end
        end
    end

    always_ff @(posedge clk) begin
        pixel_color <= next_color;
    end

endmodule

/* design/pixel_output.sv */
`timescale 1ns/1ps

module pixel_output (
    input  logic           clk,
    input  logic           reset,
    input  dino_pkg::rgb_t pixel_color,
    input  logic           active,
    input  logic           hsync_n,
    input  logic           vsync_n,
    input  logic           pixel_phase,
    output logic [7:0]     VGA_R,
    output logic [7:0]     VGA_G,
    output logic [7:0]     VGA_B,
    output logic           VGA_HS,
    output logic           VGA_VS,
    output logic           VGA_BLANK_n,
    output logic           VGA_SYNC_n,
    output logic           VGA_CLK
);

    // First delay stage, level with pixel_color
    logic active_d1;
    logic hsync_n_d1;
    logic vsync_n_d1;
    logic phase_d1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active_d1   <= 1'b0;
            hsync_n_d1  <= 1'b1;
            vsync_n_d1  <= 1'b1;
            phase_d1    <= 1'b0;
            VGA_BLANK_n <= 1'b0;
            VGA_HS      <= 1'b1;
            VGA_VS      <= 1'b1;
            VGA_CLK     <= 1'b0;
            VGA_R       <= 8'd0;
            VGA_G       <= 8'd0;
            VGA_B       <= 8'd0;
        end else begin
            active_d1   <= active;
            hsync_n_d1  <= hsync_n;
            vsync_n_d1  <= vsync_n;
            phase_d1    <= pixel_phase;
            VGA_BLANK_n <= active_d1;
            VGA_HS      <= hsync_n_d1;
            VGA_VS      <= vsync_n_d1;
            VGA_CLK     <= phase_d1;
            // Black outside the visible window
            VGA_R       <= active_d1 ? pixel_color.r : 8'd0;
            VGA_G       <= active_d1 ? pixel_color.g : 8'd0;
            VGA_B       <= active_d1 ? pixel_color.b : 8'd0;
        end
    end

    assign VGA_SYNC_n = 1'b0;

endmodule

/* design/dino_display_top.sv */
`timescale 1ns/1ps

module dino_display_top #(
    parameter int H_ACTIVE     = dino_pkg::h_active,
    parameter int H_FRONT      = dino_pkg::h_front,
    parameter int H_SYNC       = dino_pkg::h_sync,
    parameter int H_BACK       = dino_pkg::h_back,
    parameter int V_ACTIVE     = dino_pkg::v_active,
    parameter int V_FRONT      = dino_pkg::v_front,
    parameter int V_SYNC       = dino_pkg::v_sync,
    parameter int V_BACK       = dino_pkg::v_back,
    parameter int NIGHT_CYCLES = dino_pkg::night_cycles_default
) (
    input  logic                clk,
    input  logic                reset,
    input  dino_pkg::bus_word_u writedata,
    input  logic                write,
    input  logic                chipselect,
    input  dino_pkg::reg_addr_t address,
    output logic [7:0]          VGA_R,
    output logic [7:0]          VGA_G,
    output logic [7:0]          VGA_B,
    output logic                VGA_CLK,
    output logic                VGA_HS,
    output logic                VGA_VS,
    output logic                VGA_BLANK_n,
    output logic                VGA_SYNC_n
);

    import dino_pkg::*;

    coord_t     hcount;
    coord_t     vcount;
    logic       active;
    logic       hsync_n;
    logic       vsync_n;
    coord_t     dino_x;
    coord_t     dino_y;
    logic [3:0] score_digit;
    coord_t     score_x;
    coord_t     score_y;
    rgb_t       pixel_color;

    vga_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) u_vga_timing (
        .clk     (clk),
        .reset   (reset),
        .hcount  (hcount),
        .vcount  (vcount),
        .active  (active),
        .hsync_n (hsync_n),
        .vsync_n (vsync_n)
    );

    reg_decode u_reg_decode (
        .clk         (clk),
        .reset       (reset),
        .chipselect  (chipselect),
        .write       (write),
        .address     (address),
        .writedata   (writedata),
        .dino_x      (dino_x),
        .dino_y      (dino_y),
        .score_digit (score_digit),
        .score_x     (score_x),
        .score_y     (score_y)
    );

    pixel_compose #(
        .NIGHT_CYCLES (NIGHT_CYCLES)
    ) u_pixel_compose (
        .clk         (clk),
        .reset       (reset),
        .hcount      (hcount),
        .vcount      (vcount),
        .dino_x      (dino_x),
        .dino_y      (dino_y),
        .score_digit (score_digit),
        .score_x     (score_x),
        .score_y     (score_y),
        .pixel_color (pixel_color)
    );

    // Bit 0 of hcount becomes the pixel clock output
    pixel_output u_pixel_output (
        .clk         (clk),
        .reset       (reset),
        .pixel_color (pixel_color),
        .active      (active),
        .hsync_n     (hsync_n),
        .vsync_n     (vsync_n),
        .pixel_phase (hcount[0]),
        .VGA_R       (VGA_R),
        .VGA_G       (VGA_G),
        .VGA_B       (VGA_B),
        .VGA_HS      (VGA_HS),
        .VGA_VS      (VGA_VS),
        .VGA_BLANK_n (VGA_BLANK_n),
        .VGA_SYNC_n  (VGA_SYNC_n),
        .VGA_CLK     (VGA_CLK)
    );

endmodule

/* verification/dino_display_asserts.sv */
`timescale 1ns/1ps

module dino_display_asserts (
    input logic       clk,
    input logic       reset,
    input logic [7:0] r,
    input logic [7:0] g,
    input logic [7:0] b,
    input logic       hs,
    input logic       blank_n,
    input logic       sync_n
);

    // Failed assertions so far
    int fail_count = 0;

    // Blanked pixels carry no color
    blank_is_black: assert property (@(posedge clk) disable iff (reset)
        !blank_n |-> (r == 8'd0 && g == 8'd0 && b == 8'd0))
        else begin
            $error("RGB is not zero while VGA_BLANK_n is low");
            fail_count++;
        end

    // Horizontal sync only falls inside the blanking interval
    no_sync_in_window: assert property (@(posedge clk) disable iff (reset)
        blank_n |-> hs)
        else begin
            $error("VGA_HS is low while VGA_BLANK_n is high");
            fail_count++;
        end

    sync_tied_low: assert property (@(posedge clk) !sync_n)
        else begin
            $error("VGA_SYNC_n is not low");
            fail_count++;
        end

endmodule

bind pixel_output dino_display_asserts u_output_asserts (
    .clk     (clk),
    .reset   (reset),
    .r       (VGA_R),
    .g       (VGA_G),
    .b       (VGA_B),
    .hs      (VGA_HS),
    .blank_n (VGA_BLANK_n),
    .sync_n  (VGA_SYNC_n)
);

/* verification/dino_display_tb.sv */
`timescale 1ns/1ps

module dino_display_tb;

    import dino_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int H_TOTAL    = h_active + h_front + h_sync + h_back;
    localparam int V_TOTAL    = v_active + v_front + v_sync + v_back;
    localparam int FRAME      = H_TOTAL * V_TOTAL;
    localparam int NIGHT      = 1_000_000;
    // Column right of every sprite and digit position used here
    localparam int SAFE_COL   = 1270;

    logic        clk;
    logic        reset;
    logic [31:0] writedata;
    logic        write;
    logic        chipselect;
    reg_addr_t   address;
    logic [7:0]  vga_r;
    logic [7:0]  vga_g;
    logic [7:0]  vga_b;
    logic        vga_clk;
    logic        vga_hs;
    logic        vga_vs;
    logic        vga_blank_n;
    logic        vga_sync_n;
    rgb_t        vga_rgb;

    // Clocks since reset fell, which is also the DUT's pixel position
    int cyc;
    int model_dino_x;
    int model_dino_y;
    int model_digit;
    int model_score_x;
    int model_score_y;

    assign vga_rgb = {vga_r, vga_g, vga_b};

    dino_display_top #(
        .NIGHT_CYCLES (NIGHT)
    ) u_dino_display_top (
        .clk         (clk),
        .reset       (reset),
        .writedata   (writedata),
        .write       (write),
        .chipselect  (chipselect),
        .address     (address),
        .VGA_R       (vga_r),
        .VGA_G       (vga_g),
        .VGA_B       (vga_b),
        .VGA_CLK     (vga_clk),
        .VGA_HS      (vga_hs),
        .VGA_VS      (vga_vs),
        .VGA_BLANK_n (vga_blank_n),
        .VGA_SYNC_n  (vga_sync_n)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Allows 3.5 frames for the whole run
    initial begin
        #(CLK_PERIOD * (FRAME * 7 / 2));
        report_failure("Timeout: the tests did not finish within 3.5 frame times");
    end

    // Stops at the first failed output stage assertion
    initial begin
        wait (u_dino_display_top.u_pixel_output.u_output_asserts.fail_count != 0);
        report_failure("An output stage assertion failed");
    end

    // Host register model, written on the same edge as the DUT
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            cyc           <= 0;
            model_dino_x  <= 100;
            model_dino_y  <= 100;
            model_digit   <= 0;
            model_score_x <= 25;
            model_score_y <= 41;
        end else begin
            cyc <= cyc + 1;
            if (chipselect && write) begin
                case (address)
                    addr_dino_x:  model_dino_x  <= int'(writedata[10:0]);
                    addr_dino_y:  model_dino_y  <= int'(writedata[10:0]);
                    addr_score:   model_digit   <= int'(writedata[3:0]);
                    addr_score_x: model_score_x <= int'(writedata[10:0]);
                    addr_score_y: model_score_y <= int'(writedata[10:0]);
                    default: ;
                endcase
            end
        end
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_rgb(input rgb_t got, input rgb_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                     $time, what, got, exp));
        end
    endtask

    // Flag order is hs, vs, blank_n, sync_n, pixel clock
    task automatic check_sync(input logic [4:0] got, input logic [4:0] exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH at %0t: %s got %b expected %b",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            report_failure($sformatf("MISMATCH at %0t: %s got %0d expected %0d",
                                     $time, what, got, exp));
        end
    endtask

    function automatic rgb_t color_at(input int h, input int v, input bit night);
        rgb_t c;
        int   dx;
        int   dy;
        int   sx;
        int   sy;
        dx = h - model_dino_x;
        dy = v - model_dino_y;
        sx = h - model_score_x;
        sy = v - model_score_y;
        if (h >= h_active || v >= v_active) begin
            return '0;
        end
        c = (v < ground_line_row) ? (night ? sky_night : sky_day) :
            (v == ground_line_row) ? line_color :
            (v <= dark_ground_row) ? ground_light : ground_dark;
        if (dx >= 0 && dx < sprite_size && dy >= 0 && dy < sprite_size) begin
            if (dino_mask[dy][15 - dx]) c = dino_color;
        end
        if (model_digit < 10 && sx >= 0 && sx < 8 && sy >= 0 && sy < 8) begin
            if (font_rom[model_digit][sy][7 - sx]) c = digit_color;
        end
        return c;
    endfunction

    function automatic logic [4:0] flags_at(input int h, input int v);
        logic [4:0] f;
        f[4] = !(h >= h_active + h_front && h < h_active + h_front + h_sync);
        f[3] = !(v >= v_active + v_front && v < v_active + v_front + v_sync);
        f[2] = (h < h_active) && (v < v_active);
        // Composite sync is tied low
        f[1] = 1'b0;
        f[0] = h[0];
        return f;
    endfunction

    // Every output pixel is compared with the model two clocks after its position
    task automatic track_pixels();
        rgb_t       exp_color[$];
        logic [4:0] exp_flags[$];
        forever begin
            exp_color.push_back(color_at(cyc % H_TOTAL, (cyc / H_TOTAL) % V_TOTAL,
                                         cyc >= NIGHT));
            exp_flags.push_back(flags_at(cyc % H_TOTAL, (cyc / H_TOTAL) % V_TOTAL));
            @(negedge clk);
            if (exp_color.size() == 2) begin
                check_rgb(vga_rgb, exp_color.pop_front(), "pixel color");
                check_sync({vga_hs, vga_vs, vga_blank_n, vga_sync_n, vga_clk},
                           exp_flags.pop_front(), "sync flags");
            end
        end
    endtask

    task automatic wait_for_output(input int frame, input int h, input int v);
        int target;
        target = frame * FRAME + v * H_TOTAL + h + 2;
        while (cyc < target) @(negedge clk);
        if (cyc != target) begin
            report_failure("Test sequence fell behind the display position");
        end
    endtask

    task automatic bus_write(input reg_addr_t addr, input int data);
        chipselect = 1'b1;
        write      = 1'b1;
        address    = addr;
        writedata  = 32'(data);
        @(negedge clk);
        chipselect = 1'b0;
        write      = 1'b0;
    endtask

    task automatic count_black_pixels(input int frame, input int x, input int y, output int n);
        n = 0;
        for (int r = 0; r < 8; r++) begin
            wait_for_output(frame, x, y + r);
            for (int c = 0; c < 8; c++) begin
                if (vga_rgb == '0) n++;
                @(negedge clk);
            end
        end
    endtask

    task automatic reset_outputs_idle();
        @(posedge clk);
        @(negedge clk);
        check_rgb(vga_rgb, '0, "color in reset");
        check_sync({vga_hs, vga_vs, vga_blank_n, vga_sync_n, vga_clk}, 5'b11000,
                   "flags in reset");
    endtask

    task automatic day_bands_match();
        wait_for_output(0, SAFE_COL, 100);
        check_rgb(vga_rgb, sky_day, "day sky");
        wait_for_output(0, SAFE_COL, ground_line_row);
        check_rgb(vga_rgb, line_color, "ground line");
        wait_for_output(0, SAFE_COL, 290);
        check_rgb(vga_rgb, ground_light, "light ground");
        wait_for_output(0, SAFE_COL, 400);
        check_rgb(vga_rgb, ground_dark, "dark ground");
    endtask

    task automatic sync_pulses_match();
        int low_count;
        int first_low;
        low_count = 0;
        first_low = -1;
        wait_for_output(0, 0, 450);
        for (int h = 0; h < H_TOTAL; h++) begin
            if (!vga_hs) begin
                if (first_low < 0) first_low = h;
                low_count++;
            end
            @(negedge clk);
        end
        check_count(low_count, h_sync, "HS low clocks per line");
        check_count(first_low, h_active + h_front, "HS pulse start");
        low_count = 0;
        first_low = -1;
        for (int v = 482; v < 500; v++) begin
            wait_for_output(0, 0, v);
            if (!vga_vs) begin
                if (first_low < 0) first_low = v;
                low_count++;
            end
        end
        check_count(low_count, v_sync, "VS low lines");
        check_count(first_low, v_active + v_front, "VS pulse start");
    endtask

    task automatic sprite_follows_writes();
        int new_x;
        int new_y;
        int opaque;
        int seen;
        new_x  = $urandom_range(1200);
        new_y  = 60 + $urandom_range(400);
        opaque = 0;
        seen   = 0;
        // Moved during vertical blanking so frame 1 is drawn whole
        wait_for_output(0, 0, 505);
        bus_write(addr_dino_x, new_x);
        bus_write(addr_dino_y, new_y);
        for (int r = 0; r < sprite_size; r++) begin
            opaque += $countones(dino_mask[r]);
            wait_for_output(1, new_x, new_y + r);
            for (int c = 0; c < sprite_size; c++) begin
                if (vga_rgb == dino_color) seen++;
                @(negedge clk);
            end
        end
        check_count(seen, opaque, "opaque sprite pixels");
    endtask

    task automatic score_digit_draws();
        int digit;
        int pos_x;
        int pos_y;
        int lit;
        int dark;
        for (int i = 0; i < 3; i++) begin
            digit = $urandom_range(9);
            pos_x = $urandom_range(1200);
            pos_y = 30 + 90 * i + $urandom_range(40);
            lit   = 0;
            for (int r = 0; r < 8; r++) begin
                lit += $countones(font_rom[digit][r]);
            end
            // Each new digit lands below the box that was just scanned
            wait_for_output(2, 0, 20 + 90 * i);
            bus_write(addr_score, digit);
            bus_write(addr_score_x, pos_x);
            bus_write(addr_score_y, pos_y);
            count_black_pixels(2, pos_x, pos_y, dark);
            check_count(dark, lit, $sformatf("black pixels of digit %0d", digit));
        end
    endtask

    task automatic night_sky_appears();
        wait_for_output(2, SAFE_COL, 270);
        check_rgb(vga_rgb, sky_night, "night sky");
        wait_for_output(2, SAFE_COL, 290);
        check_rgb(vga_rgb, ground_light, "light ground at night");
        wait_for_output(2, SAFE_COL, 400);
        check_rgb(vga_rgb, ground_dark, "dark ground at night");
    endtask

    task automatic ignored_writes_harmless();
        int pos_x;
        int pos_y;
        int dark;
        pos_x = $urandom_range(1200);
        pos_y = 20 + $urandom_range(20);
        wait_for_output(2, 0, 505);
        bus_write(addr_score, 12);
        bus_write(addr_score_x, pos_x);
        bus_write(addr_score_y, pos_y);
        for (int a = 5; a < 8; a++) begin
            bus_write(reg_addr_t'(a), $urandom);
        end
        count_black_pixels(3, pos_x, pos_y, dark);
        check_count(dark, 0, "black pixels of digit 12");
    endtask

    initial begin
        void'($urandom(67377));
        reset      = 1'b1;
        write      = 1'b0;
        chipselect = 1'b0;
        address    = addr_dino_x;
        writedata  = '0;
        reset_outputs_idle();
        @(negedge clk);
        reset = 1'b0;
        fork
            track_pixels();
        join_none
        day_bands_match();
        sync_pulses_match();
        sprite_follows_writes();
        score_digit_draws();
        night_sky_appears();
        ignored_writes_harmless();
        if (u_dino_display_top.u_pixel_output.u_output_asserts.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display("Output stage assertions failed during the run");
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
design/dino_pkg.sv
design/vga_timing.sv
design/reg_decode.sv
design/pixel_compose.sv
design/pixel_output.sv
design/dino_display_top.sv
verification/dino_display_asserts.sv
verification/dino_display_tb.sv
